//--- include/gtia_consts.svh
// Widths, register map and default raster size of the pixel generator
// Included by the package and by every module that needs these values
`ifndef GTIA_CONSTS_SVH
`define GTIA_CONSTS_SVH

`define GTIA_COLOR_W 8
`define GTIA_X_W 9
`define GTIA_Y_W 8
`define GTIA_ADR_W 5

// Player/missile horizontal position of the first visible pixel
`define GTIA_HPOS_OFFSET 8'h30

`define GTIA_LINE_WIDTH 320
`define GTIA_FRAME_LINES 192

`define GTIA_HPOSP0 5'h00
`define GTIA_HPOSM0 5'h04
`define GTIA_GRAFP0 5'h0D
`define GTIA_GRAFM 5'h11
`define GTIA_COLPM0 5'h12
`define GTIA_COLPF0 5'h16
`define GTIA_COLBK 5'h1A
`define GTIA_PRIOR 5'h1B
`define GTIA_HITCLR 5'h1E

`endif

//--- src/gtiaPkg.sv
// Shared types of the pixel generator: pixel codes, priority rules
// and the structs passed between the datapath blocks
`include "gtia_consts.svh"

package gtiaPkg;

  typedef enum logic [3:0] {
    anNone       = 4'd0,
    anBackground = 4'd1,
    anVsync      = 4'd2,
    anHblank     = 4'd3,
    anLum1Col2   = 4'd4,
    anPf0        = 4'd5,
    anPf1        = 4'd6,
    anPf2        = 4'd7,
    anPf3        = 4'd8
  } anCode;

  // PRIOR bit 0
  typedef enum logic {
    prioMix          = 1'b0,
    prioPlayersFirst = 1'b1
  } priorityMode;

  typedef struct packed {
    logic [3:0][7:0]                     hposP;
    logic [3:0][7:0]                     hposM;
    logic [3:0][7:0]                     grafP;
    logic [7:0]                          grafM;
    logic [3:0][`GTIA_COLOR_W-1:0]       colPm;
    logic [3:0][`GTIA_COLOR_W-1:0]       colPf;
    logic [`GTIA_COLOR_W-1:0]            colBk;
    logic [7:0]                          prior;
  } colorRegs;

  typedef struct packed {
    logic                     valid;
    logic [`GTIA_COLOR_W-1:0] color;
    anCode                    kind;
    logic [`GTIA_X_W-1:0]     x;
    logic [`GTIA_Y_W-1:0]     y;
    logic                     lineEnd;
    logic                     frameEnd;
  } pixelBase;

  typedef struct packed {
    logic [3:0] player;
    logic [3:0] missile;
  } pmHits;

  // Index order matches the collision read map M0PF..P3PL
  typedef struct packed {
    logic [3:0][3:0] mPf;
    logic [3:0][3:0] pPf;
    logic [3:0][3:0] mPl;
    logic [3:0][3:0] pPl;
  } collisionState;

endpackage

//--- src/gtiaRegs.sv
// Wishbone classic slave for the register file
// Writes load the colour/position/graphics registers, reads return collisions
`timescale 1ns/1ns
`include "gtia_consts.svh"

module gtiaRegs
  import gtiaPkg::*;
(
  input  logic                   Fphi0,
  input  logic                   rst,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [`GTIA_ADR_W-1:0] adr,
  input  logic [7:0]             datIn,
  input  collisionState          coll,
  output logic [7:0]             datOut,
  output logic                   ack,
  output colorRegs               regs,
  output logic                   hitClear
);

  localparam logic [`GTIA_ADR_W-1:0] grpSize = 4;

  logic                   req;
  logic [`GTIA_ADR_W-1:0] offHposP;
  logic [`GTIA_ADR_W-1:0] offHposM;
  logic [`GTIA_ADR_W-1:0] offGrafP;
  logic [`GTIA_ADR_W-1:0] offColPm;
  logic [`GTIA_ADR_W-1:0] offColPf;
  logic [3:0]             collField;

  // New cycle only while ack is low, so each strobe gets one ack
  assign req = cyc && stb && !ack;

  // Offsets into the four-register groups, out of range wraps high
  assign offHposP = adr - `GTIA_HPOSP0;
  assign offHposM = adr - `GTIA_HPOSM0;
  assign offGrafP = adr - `GTIA_GRAFP0;
  assign offColPm = adr - `GTIA_COLPM0;
  assign offColPf = adr - `GTIA_COLPF0;

  always_comb begin
    case (adr[3:2])
      2'd0:    collField = coll.mPf[adr[1:0]];
      2'd1:    collField = coll.pPf[adr[1:0]];
      2'd2:    collField = coll.mPl[adr[1:0]];
      default: collField = coll.pPl[adr[1:0]];
    endcase
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      ack      <= 1'b0;
      hitClear <= 1'b0;
      datOut   <= '0;
      regs     <= '0;
    end else begin
      ack      <= req;
      hitClear <= req && we && (adr == `GTIA_HITCLR);
      if (req && !we) begin
        // Only 0x00-0x0F hold collision registers
        datOut <= adr[4] ? 8'h00 : {4'h0, collField};
      end
      if (req && we) begin
        if (offHposP < grpSize)
          regs.hposP[offHposP[1:0]] <= datIn;
        if (offHposM < grpSize)
          regs.hposM[offHposM[1:0]] <= datIn;
        if (offGrafP < grpSize)
          regs.grafP[offGrafP[1:0]] <= datIn;
        if (offColPm < grpSize)
          regs.colPm[offColPm[1:0]] <= datIn;
        if (offColPf < grpSize)
          regs.colPf[offColPf[1:0]] <= datIn;
        if (adr == `GTIA_GRAFM)
          regs.grafM <= datIn;
        if (adr == `GTIA_COLBK)
          regs.colBk <= datIn;
        if (adr == `GTIA_PRIOR)
          regs.prior <= datIn;
      end
    end
  end

endmodule

//--- src/pixelControl.sv
// Turns incoming pixel codes into base colours and steps the raster
// position, one scan line per mode line
`timescale 1ns/1ns
`include "gtia_consts.svh"

module pixelControl
  import gtiaPkg::*;
#(
  parameter int lineWidth  = `GTIA_LINE_WIDTH,
  parameter int frameLines = `GTIA_FRAME_LINES
) (
  input  logic     Fphi0,
  input  logic     rst,
  input  anCode    an,
  input  colorRegs regs,
  output pixelBase pix
);

  localparam int xW = `GTIA_X_W;
  localparam int yW = `GTIA_Y_W;
  localparam logic [xW-1:0] xLast = xW'(lineWidth - 1);
  localparam logic [yW-1:0] yLast = yW'(frameLines - 1);

  logic                     normalMode;
  logic                     isColor;
  logic [`GTIA_COLOR_W-1:0] baseColor;
  logic [xW-1:0]            x;
  logic [yW-1:0]            y;
  logic                     lastX;
  logic                     lastY;

  // PRIOR bits 7:6 pick the mode, 00 is normal
  assign normalMode = regs.prior[7:6] == 2'b00;
  assign lastX      = x == xLast;
  assign lastY      = y == yLast;

  always_comb begin
    isColor   = 1'b1;
    baseColor = '0;
    case (an)
      anBackground: baseColor = regs.colBk;
      anLum1Col2:   baseColor = {regs.colPf[2][7:4], regs.colPf[1][3:0]};
      anPf0:        baseColor = regs.colPf[0];
      anPf1:        baseColor = regs.colPf[1];
      anPf2:        baseColor = regs.colPf[2];
      anPf3:        baseColor = regs.colPf[3];
      default:      isColor = 1'b0;
    endcase
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      x   <= '0;
      y   <= '0;
      pix <= '0;
    end else begin
      pix.valid    <= normalMode && isColor;
      pix.lineEnd  <= normalMode && isColor && lastX;
      pix.frameEnd <= normalMode && isColor && lastX && lastY;
      if (normalMode) begin
        if (an == anVsync) begin
          x <= '0;
          y <= '0;
        end else if (an == anHblank) begin
          x <= '0;
          y <= lastY ? '0 : y + 1'b1;
        end else if (isColor) begin
          pix.color <= baseColor;
          pix.kind  <= an;
          pix.x     <= x;
          pix.y     <= y;
          x         <= lastX ? '0 : x + 1'b1;
          if (lastX)
            y <= lastY ? '0 : y + 1'b1;
        end
      end
    end
  end

endmodule

//--- src/spriteMatch.sv
// Finds the players and missiles covering the current pixel
`timescale 1ns/1ns
`include "gtia_consts.svh"

module spriteMatch
  import gtiaPkg::*;
(
  input  colorRegs regs,
  input  pixelBase pix,
  output pmHits    hits
);

  logic [7:0]      hpos;
  logic [3:0][7:0] dPlayer;
  logic [3:0][7:0] dMissile;

  // Two raster pixels per colour clock
  assign hpos = pix.x[`GTIA_X_W-1:1] + `GTIA_HPOS_OFFSET;

  always_comb begin
    hits = '0;
    for (int i = 0; i < 4; i++) begin
      dPlayer[i]  = hpos - regs.hposP[i];
      dMissile[i] = hpos - regs.hposM[i];
      // No wrap past 0xFF, an object near the right edge is clipped
      if (pix.valid && hpos >= regs.hposP[i] && dPlayer[i] < 8'd8)
        hits.player[i] = regs.grafP[i][3'd7 - dPlayer[i][2:0]];
      // Missile n owns GRAFM bits 2n+1 (left) and 2n
      if (pix.valid && hpos >= regs.hposM[i] && dMissile[i] < 8'd2)
        hits.missile[i] = regs.grafM[2*i + 1 - dMissile[i][0]];
    end
  end

endmodule

//--- src/priorityMux.sv
// Picks the shown colour from the base colour, sprite hits and PRIOR rule
`timescale 1ns/1ns
`include "gtia_consts.svh"

module priorityMux
  import gtiaPkg::*;
(
  input  colorRegs                 regs,
  input  pixelBase                 pix,
  input  pmHits                    hits,
  output logic [`GTIA_COLOR_W-1:0] pixelColor
);

  priorityMode mode;
  logic [3:0]  pairHit;
  logic        lowPf;
  logic        highPf;

  // Player over a playfield of its own group blends with it
  function automatic logic [`GTIA_COLOR_W-1:0] overlay(
    input logic [`GTIA_COLOR_W-1:0] pm,
    input logic                     player,
    input logic                     ownPf,
    input logic [`GTIA_COLOR_W-1:0] base
  );
    return (player && ownPf) ? (pm | base) : pm;
  endfunction

  assign mode    = priorityMode'(regs.prior[0]);
  assign pairHit = hits.player | hits.missile;
  assign lowPf   = pix.kind == anPf0 || pix.kind == anPf1;
  assign highPf  = pix.kind == anPf2 || pix.kind == anPf3;

  always_comb begin
    pixelColor = pix.color;
    if (mode == prioPlayersFirst) begin
      // Lowest pair wins, no blending in this rule
      for (int i = 3; i >= 0; i--) begin
        if (pairHit[i])
          pixelColor = regs.colPm[i];
      end
    end else if (pairHit[0]) begin
      pixelColor = overlay(regs.colPm[0], hits.player[0], lowPf, pix.color);
    end else if (pairHit[1]) begin
      pixelColor = overlay(regs.colPm[1], hits.player[1], lowPf, pix.color);
    end else if (!lowPf && pairHit[2]) begin
      pixelColor = overlay(regs.colPm[2], hits.player[2], highPf, pix.color);
    end else if (!lowPf && pairHit[3]) begin
      pixelColor = overlay(regs.colPm[3], hits.player[3], highPf, pix.color);
    end
  end

endmodule

//--- src/collisionLatch.sv
// Sticky player/missile collision bits, cleared by a HITCLR write
`timescale 1ns/1ns

module collisionLatch
  import gtiaPkg::*;
(
  input  logic          Fphi0,
  input  logic          rst,
  input  pixelBase      pix,
  input  pmHits         hits,
  input  logic          hitClear,
  output collisionState coll
);

  logic [3:0] pfBits;

  // One-hot playfield of the pixel, zero for other kinds
  always_comb begin
    case (pix.kind)
      anPf0:   pfBits = 4'b0001;
      anPf1:   pfBits = 4'b0010;
      anPf2:   pfBits = 4'b0100;
      anPf3:   pfBits = 4'b1000;
      default: pfBits = 4'b0000;
    endcase
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      coll <= '0;
    end else if (hitClear) begin
      coll <= '0;
    end else if (pix.valid) begin
      for (int i = 0; i < 4; i++) begin
        coll.mPf[i] <= coll.mPf[i] | (hits.missile[i] ? pfBits : 4'b0000);
        coll.pPf[i] <= coll.pPf[i] | (hits.player[i] ? pfBits : 4'b0000);
        coll.mPl[i] <= coll.mPl[i] | (hits.missile[i] ? hits.player : 4'b0000);
        // A player never collides with itself
        coll.pPl[i] <= coll.pPl[i] |
                       (hits.player[i] ? (hits.player & ~(4'b0001 << i)) : 4'b0000);
      end
    end
  end

endmodule

//--- src/gtia.sv
// Top of the pixel generator: register port, raster control, sprites,
// priority and collisions
`timescale 1ns/1ns
`include "gtia_consts.svh"

module gtia
  import gtiaPkg::*;
#(
  parameter int lineWidth  = `GTIA_LINE_WIDTH,
  parameter int frameLines = `GTIA_FRAME_LINES
) (
  input  logic                     Fphi0,
  input  logic                     rst,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [`GTIA_ADR_W-1:0]   adr,
  input  logic [7:0]               datIn,
  output logic [7:0]               datOut,
  output logic                     ack,
  input  anCode                    an,
  output logic                     pixelValid,
  output logic [`GTIA_COLOR_W-1:0] pixelColor,
  output logic [`GTIA_X_W-1:0]     pixelX,
  output logic [`GTIA_Y_W-1:0]     pixelY,
  output logic                     hblank,
  output logic                     vblank
);

  colorRegs      regs;
  pixelBase      pix;
  pmHits         hits;
  collisionState coll;
  logic          hitClear;

  gtiaRegs iRegs (
    .Fphi0(Fphi0), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datIn(datIn), .coll(coll), .datOut(datOut), .ack(ack), .regs(regs),
    .hitClear(hitClear)
  );

  pixelControl #(.lineWidth(lineWidth), .frameLines(frameLines)) iCtrl (
    .Fphi0(Fphi0), .rst(rst), .an(an), .regs(regs), .pix(pix)
  );

  spriteMatch iSprites (.regs(regs), .pix(pix), .hits(hits));

  priorityMux iPrio (.regs(regs), .pix(pix), .hits(hits), .pixelColor(pixelColor));

  collisionLatch iColl (
    .Fphi0(Fphi0), .rst(rst), .pix(pix), .hits(hits), .hitClear(hitClear), .coll(coll)
  );

  assign pixelValid = pix.valid;
  assign pixelX     = pix.x;
  assign pixelY     = pix.y;
  assign hblank     = pix.lineEnd;
  assign vblank     = pix.frameEnd;

endmodule

//--- test/gtia_sva.sv
// Bus handshake and pixel-output rules, bound into the top level
`timescale 1ns/1ns

module gtiaSva
  import gtiaPkg::*;
(
  input logic       Fphi0,
  input logic       rst,
  input logic       cyc,
  input logic       stb,
  input logic       ack,
  input anCode      an,
  input logic [1:0] mode,
  input logic       pixelValid,
  input logic       hblank,
  input logic       vblank
);

  logic colorCode;
  logic normal;
  int   failCount = 0;

  assign colorCode = (an == anBackground) || (an == anLum1Col2) ||
                     (an >= anPf0 && an <= anPf3);
  assign normal    = mode == 2'b00;

  ackOnePulse: assert property (@(posedge Fphi0) disable iff (rst) ack |=> !ack)
    else begin
      failCount++;
      $error("ack stayed high for more than one cycle");
    end

  ackAfterStb: assert property (@(posedge Fphi0) disable iff (rst)
    $rose(ack) |-> $past(cyc && stb))
    else begin
      failCount++;
      $error("ack rose without a strobe in the cycle before");
    end

  pixelAfterCode: assert property (@(posedge Fphi0) disable iff (rst)
    (normal && colorCode) |=> pixelValid)
    else begin
      failCount++;
      $error("colour code in normal mode produced no pixel");
    end

  pixelNeedsCode: assert property (@(posedge Fphi0) disable iff (rst)
    pixelValid |-> $past(normal && colorCode))
    else begin
      failCount++;
      $error("pixel appeared without a colour code one cycle earlier");
    end

  vblankInHblank: assert property (@(posedge Fphi0) disable iff (rst) vblank |-> hblank)
    else begin
      failCount++;
      $error("vblank set without hblank");
    end

endmodule

bind gtia gtiaSva iSva (
  .Fphi0(Fphi0), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack), .an(an),
  .mode(regs.prior[7:6]), .pixelValid(pixelValid), .hblank(hblank), .vblank(vblank)
);

//--- test/gtiaTb.sv
// Testbench for the pixel generator: random register writes and pixel codes
// checked against a reference model of colours, raster position and collisions
`timescale 1ns/1ns
`include "gtia_consts.svh"

module gtiaTb
  import gtiaPkg::*;
();

  localparam int lineW      = 16;
  localparam int frameH     = 4;
  localparam int frameCodes = lineW * frameH;

  // Loop counts of the tests set the cycle limit
  localparam int nRandWrites  = 24;
  localparam int nBaseCodes   = 160;
  localparam int nRasterCodes = 80;
  localparam int nOffCodes    = 30;
  localparam int nPrioRounds  = 4;
  localparam int busOps       = 18 + nRandWrites + 14 + 2 + nPrioRounds * 18 + 67;
  localparam int pixelCodes   = nBaseCodes + nRasterCodes + nOffCodes + 10 + 10 +
                                (nPrioRounds + 1) * 2 * frameCodes;
  // Three clocks per bus cycle and a margin of three
  localparam int maxCycles    = 3 * (3 * busOps + pixelCodes);

  logic                     Fphi0;
  logic                     rst;
  logic                     cyc;
  logic                     stb;
  logic                     we;
  logic [`GTIA_ADR_W-1:0]   adr;
  logic [7:0]               datIn;
  logic [7:0]               datOut;
  logic                     ack;
  anCode                    an;
  logic                     pixelValid;
  logic [`GTIA_COLOR_W-1:0] pixelColor;
  logic [`GTIA_X_W-1:0]     pixelX;
  logic [`GTIA_Y_W-1:0]     pixelY;
  logic                     hblank;
  logic                     vblank;

  // Reference model
  colorRegs   mr;
  logic [3:0] mColl [16];
  int         mx;
  int         my;
  pixelBase   pend;
  pmHits      pendHits;

  integer seed = 32'hd213_9375;
  int     cycles = 0;
  int     checks;
  int     errors;
  int     errStart;
  string  testName;
  anCode  colorCodes [6] = '{anBackground, anLum1Col2, anPf0, anPf1, anPf2, anPf3};

  gtia #(.lineWidth(lineW), .frameLines(frameH)) i_dut (
    .Fphi0(Fphi0), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datIn(datIn), .datOut(datOut), .ack(ack), .an(an), .pixelValid(pixelValid),
    .pixelColor(pixelColor), .pixelX(pixelX), .pixelY(pixelY),
    .hblank(hblank), .vblank(vblank)
  );

  initial begin
    Fphi0 = 1'b0;
    forever #50 Fphi0 = ~Fphi0;
  end

  always @(posedge Fphi0) begin
    cycles = cycles + 1;
    if (cycles >= maxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", maxCycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic checkColor(input logic [`GTIA_COLOR_W-1:0] expected,
                            input logic [`GTIA_COLOR_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s colour: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic checkPos(input logic [`GTIA_X_W-1:0] expX, input logic [`GTIA_Y_W-1:0] expY,
                          input logic [`GTIA_X_W-1:0] actX, input logic [`GTIA_Y_W-1:0] actY);
    checks++;
    if (actX !== expX || actY !== expY) begin
      errors++;
      $display("[FAIL] %s position: expected (%0d,%0d), actual (%0d,%0d)",
               testName, expX, expY, actX, actY);
    end
  endtask

  // Bits are valid, hblank, vblank
  task automatic checkFlags(input logic [2:0] expected, input logic [2:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s valid/hblank/vblank: expected %b, actual %b",
               testName, expected, actual);
    end
  endtask

  task automatic checkColl(input logic [`GTIA_ADR_W-1:0] a, input logic [7:0] expected,
                           input logic [7:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s collision read %h: expected %h, actual %h",
               testName, a, expected, actual);
    end
  endtask

  task automatic modelWrite(input logic [`GTIA_ADR_W-1:0] a, input logic [7:0] d);
    if (a < `GTIA_HPOSM0)
      mr.hposP[a[1:0]] = d;
    else if (a < `GTIA_HPOSM0 + 5'd4)
      mr.hposM[a[1:0]] = d;
    else if (a >= `GTIA_GRAFP0 && a < `GTIA_GRAFM)
      mr.grafP[2'(a - `GTIA_GRAFP0)] = d;
    else if (a == `GTIA_GRAFM)
      mr.grafM = d;
    else if (a >= `GTIA_COLPM0 && a < `GTIA_COLPF0)
      mr.colPm[2'(a - `GTIA_COLPM0)] = d;
    else if (a >= `GTIA_COLPF0 && a < `GTIA_COLBK)
      mr.colPf[2'(a - `GTIA_COLPF0)] = d;
    else if (a == `GTIA_COLBK)
      mr.colBk = d;
    else if (a == `GTIA_PRIOR)
      mr.prior = d;
    else if (a == `GTIA_HITCLR)
      for (int i = 0; i < 16; i++)
        mColl[i] = 4'h0;
  endtask

  function automatic pmHits hitsAt(input int x);
    pmHits h;
    int    hp;
    int    d;
    h  = '0;
    hp = x / 2 + 48;
    for (int i = 0; i < 4; i++) begin
      d = hp - int'(mr.hposP[i]);
      if (d >= 0 && d < 8)
        h.player[i] = mr.grafP[i][7 - d];
      d = hp - int'(mr.hposM[i]);
      if (d >= 0 && d < 2)
        h.missile[i] = mr.grafM[2 * i + 1 - d];
    end
    return h;
  endfunction

  function automatic logic [`GTIA_COLOR_W-1:0] shownColor(
    input logic [`GTIA_COLOR_W-1:0] base,
    input anCode                    kind,
    input pmHits                    h
  );
    logic [3:0]               pair;
    logic                     mix;
    logic                     pfLow;
    logic                     done;
    logic [`GTIA_COLOR_W-1:0] c;
    pair  = h.player | h.missile;
    mix   = priorityMode'(mr.prior[0]) == prioMix;
    pfLow = (kind == anPf0) || (kind == anPf1);
    c     = base;
    done  = 1'b0;
    for (int i = 0; i < 4; i++) begin
      // PF0 and PF1 sit above pairs 2 and 3 under the mix rule
      if (mix && i == 2 && pfLow)
        done = 1'b1;
      if (!done && pair[i]) begin
        c = mr.colPm[i];
        if (mix && h.player[i] && (i < 2 ? pfLow : (kind == anPf2 || kind == anPf3)))
          c = c | base;
        done = 1'b1;
      end
    end
    return c;
  endfunction

  task automatic modelCode(input anCode c);
    logic [`GTIA_COLOR_W-1:0] base;
    logic                     isColor;
    pend     = '0;
    pendHits = '0;
    isColor  = 1'b1;
    base     = mr.colBk;
    if (c == anLum1Col2)
      base = {mr.colPf[2][7:4], mr.colPf[1][3:0]};
    else if (c >= anPf0 && c <= anPf3)
      base = mr.colPf[c - anPf0];
    else if (c != anBackground)
      isColor = 1'b0;
    if (mr.prior[7:6] == 2'b00) begin
      if (c == anVsync) begin
        mx = 0;
        my = 0;
      end else if (c == anHblank) begin
        mx = 0;
        my = (my + 1) % frameH;
      end else if (isColor) begin
        pend.valid    = 1'b1;
        pend.kind     = c;
        pend.x        = mx[`GTIA_X_W-1:0];
        pend.y        = my[`GTIA_Y_W-1:0];
        pend.lineEnd  = mx == lineW - 1;
        pend.frameEnd = pend.lineEnd && (my == frameH - 1);
        pendHits      = hitsAt(mx);
        pend.color    = shownColor(base, c, pendHits);
        mx            = (mx + 1) % lineW;
        if (mx == 0)
          my = (my + 1) % frameH;
      end
    end
  endtask

  task automatic modelCollide(input anCode kind, input pmHits h);
    logic [3:0] pf;
    pf = 4'h0;
    if (kind >= anPf0 && kind <= anPf3)
      pf[kind - anPf0] = 1'b1;
    for (int i = 0; i < 4; i++) begin
      if (h.missile[i]) begin
        mColl[i]     = mColl[i] | pf;
        mColl[8 + i] = mColl[8 + i] | h.player;
      end
      if (h.player[i]) begin
        mColl[4 + i] = mColl[4 + i] | pf;
        for (int j = 0; j < 4; j++)
          if (j != i && h.player[j])
            mColl[12 + i][j] = 1'b1;
      end
    end
  endtask

  task automatic busCycle(input logic [`GTIA_ADR_W-1:0] a, input logic w,
                          input logic [7:0] d, output logic [7:0] q);
    int waitCnt;
    waitCnt = 0;
    @(posedge Fphi0);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= w;
    adr   <= a;
    datIn <= d;
    @(negedge Fphi0);
    while (!ack && waitCnt < 8) begin
      @(negedge Fphi0);
      waitCnt++;
    end
    q = datOut;
    if (!ack) begin
      errors++;
      $display("%s: no ack for the bus cycle at address %h", testName, a);
    end
    @(posedge Fphi0);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(negedge Fphi0);
    if (ack) begin
      errors++;
      $display("%s: ack held past one cycle at address %h", testName, a);
    end
  endtask

  task automatic regWrite(input logic [`GTIA_ADR_W-1:0] a, input logic [7:0] d);
    logic [7:0] unusedQ;
    busCycle(a, 1'b1, d, unusedQ);
    modelWrite(a, d);
  endtask

  task automatic collRead(input logic [`GTIA_ADR_W-1:0] a);
    logic [7:0] q;
    logic [7:0] expected;
    expected = (a < 5'h10) ? {4'h0, mColl[a[3:0]]} : 8'h00;
    busCycle(a, 1'b0, 8'h00, q);
    checkColl(a, expected, q);
  endtask

  // Output seen at this negedge belongs to the code of the previous call
  task automatic sendCode(input anCode code);
    @(posedge Fphi0);
    an <= code;
    @(negedge Fphi0);
    checkFlags({pend.valid, pend.lineEnd, pend.frameEnd}, {pixelValid, hblank, vblank});
    if (pend.valid) begin
      checkPos(pend.x, pend.y, pixelX, pixelY);
      checkColor(pend.color, pixelColor);
      modelCollide(pend.kind, pendHits);
    end
    modelCode(code);
  endtask

  task automatic setSprites(input logic [7:0] prior);
    for (int i = 0; i < 4; i++) begin
      regWrite(`GTIA_HPOSP0 + 5'(i), 8'(8'h28 + randBelow(16)));
      regWrite(`GTIA_HPOSM0 + 5'(i), 8'(8'h28 + randBelow(16)));
      regWrite(`GTIA_GRAFP0 + 5'(i), 8'(randBelow(256)));
      regWrite(`GTIA_COLPM0 + 5'(i), 8'(randBelow(256)));
    end
    regWrite(`GTIA_GRAFM, 8'(randBelow(256)));
    regWrite(`GTIA_PRIOR, prior);
  endtask

  task automatic startTest(input string name);
    testName = name;
    errStart = errors;
  endtask

  task automatic endTest();
    $display("%s finished, %0d errors", testName, errors - errStart);
  endtask

  initial begin
    int r;
    rst      = 1'b1;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    datIn    = '0;
    an       = anNone;
    mr       = '0;
    mx       = 0;
    my       = 0;
    pend     = '0;
    pendHits = '0;
    checks   = 0;
    errors   = 0;
    for (int i = 0; i < 16; i++)
      mColl[i] = 4'h0;
    repeat (3) @(posedge Fphi0);
    rst <= 1'b0;

    startTest("registerBus");
    for (int a = 0; a < 18; a++)
      collRead(5'(a));
    for (int i = 0; i < nRandWrites; i++)
      regWrite(5'(randBelow(32)), 8'(randBelow(256)));
    endTest();

    // Sprites parked at position 0 never reach the visible range
    startTest("baseColors");
    for (int i = 0; i < 4; i++) begin
      regWrite(`GTIA_HPOSP0 + 5'(i), 8'h00);
      regWrite(`GTIA_HPOSM0 + 5'(i), 8'h00);
      regWrite(`GTIA_COLPF0 + 5'(i), 8'(randBelow(256)));
    end
    regWrite(`GTIA_COLBK, 8'(randBelow(256)));
    regWrite(`GTIA_PRIOR, 8'h00);
    for (int i = 0; i < nBaseCodes; i++)
      sendCode(colorCodes[randBelow(6)]);
    sendCode(anNone);
    endTest();

    startTest("rasterControl");
    for (int i = 0; i < nRasterCodes; i++) begin
      r = randBelow(8);
      if (r == 0)
        sendCode(anVsync);
      else if (r < 3)
        sendCode(anHblank);
      else if (r == 3)
        sendCode(anNone);
      else
        sendCode(colorCodes[randBelow(6)]);
    end
    sendCode(anNone);
    regWrite(`GTIA_PRIOR, 8'(1 + randBelow(3)) << 6);
    for (int i = 0; i < nOffCodes; i++)
      sendCode(anCode'(randBelow(9)));
    sendCode(anNone);
    regWrite(`GTIA_PRIOR, 8'h00);
    for (int i = 0; i < 10; i++)
      sendCode(colorCodes[randBelow(6)]);
    sendCode(anNone);
    endTest();

    startTest("priority");
    for (int k = 0; k < nPrioRounds; k++) begin
      setSprites(8'(k % 2));
      for (int i = 0; i < 2 * frameCodes; i++)
        sendCode(colorCodes[randBelow(6)]);
      sendCode(anNone);
    end
    endTest();

    startTest("collisions");
    for (int a = 0; a < 16; a++)
      collRead(5'(a));
    regWrite(`GTIA_HITCLR, 8'(randBelow(256)));
    for (int a = 0; a < 16; a++)
      collRead(5'(a));
    setSprites(8'h00);
    for (int i = 0; i < 2 * frameCodes; i++)
      sendCode(colorCodes[randBelow(6)]);
    sendCode(anNone);
    for (int a = 0; a < 16; a++)
      collRead(5'(a));
    endTest();

    // Failed bound assertions count as errors too
    errors = errors + i_dut.iSva.failCount;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- gtia.f
+incdir+include
src/gtiaPkg.sv
src/gtiaRegs.sv
src/pixelControl.sv
src/spriteMatch.sv
src/priorityMux.sv
src/collisionLatch.sv
src/gtia.sv
test/gtia_sva.sv
test/gtiaTb.sv

//--- run.sh
#!/bin/sh
# Builds the pixel generator testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f gtia.f --top-module gtiaTb \
  -o gtiaSim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/gtiaSim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"
